// File: common/corePkg.sv
package corePkg;

    localparam int dataWidth = 32;
    localparam int regCount = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 11;
    localparam int shamtWidth = 5;

    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [dataWidth-1:0] dataT;

    typedef enum logic [5:0] {
        opAdd    = 6'h01,
        opSub    = 6'h02,
        opAnd    = 6'h03,
        opOr     = 6'h04,
        opXor    = 6'h05,
        opShl    = 6'h06,
        opAddImm = 6'h07,
        opMul    = 6'h08
    } opCodeT;

    // raw word as it arrives on the instruction port
    typedef struct packed {
        logic [5:0]          opCode;
        regAddrT             rd;
        regAddrT             rs;
        regAddrT             rt;
        logic [immWidth-1:0] imm;
    } instrT;

    typedef struct packed {
        opCodeT                op;
        regAddrT               rd;
        logic                  we;
        dataT                  operandA;
        dataT                  operandB;
        dataT                  immediate; // sign-extended.
        logic [shamtWidth-1:0] shamt;
    } decodedT;

    typedef struct packed {
        regAddrT rd;
        logic    we;
        logic    isMul;
        dataT    value;
    } execResultT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
        dataT    data;
    } writeBackT;

    // undefined codes decode to a no-op
    function automatic logic isWriteOp(logic [5:0] code);
        logic known;
        known = 1'b0;
        case (code)
            opAdd, opSub, opAnd, opOr, opXor, opShl, opAddImm, opMul: known = 1'b1;
            default: known = 1'b0;
        endcase
        return known;
    endfunction

endpackage

// File: decode/registerFile.sv
`timescale 1ns/1ps

module registerFile import corePkg::*; (
    input  logic      Clock,
    input  logic      nReset,
    input  regAddrT   rsAddr,
    input  regAddrT   rtAddr,
    output dataT      rsData,
    output dataT      rtData,
    input  writeBackT writeBack,
    input  regAddrT   RegAddr,
    output dataT      RegData
);

    dataT regs [regCount];

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end else if (writeBack.en && writeBack.addr != '0) begin
            regs[writeBack.addr] <= writeBack.data;
        end
    end

    // write-through so a read in the write cycle sees new data
    function automatic dataT readPort(regAddrT addr, dataT stored);
        dataT value;
        value = stored;
        if (addr == '0)
            value = '0;
        else if (writeBack.en && writeBack.addr == addr)
            value = writeBack.data;
        return value;
    endfunction

    assign rsData  = readPort(rsAddr, regs[rsAddr]);
    assign rtData  = readPort(rtAddr, regs[rtAddr]);
    assign RegData = readPort(RegAddr, regs[RegAddr]);

endmodule

// File: decode/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import corePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  logic       instrValid,
    output logic       instrReady,
    input  instrT      instr,
    input  execResultT midFwd,
    input  logic       midFwdValid,
    input  execResultT execFwd,
    input  logic       execFwdValid,
    input  dataT       aluFwd,
    input  logic       busyMul,
    input  regAddrT    busyMulRd,
    input  writeBackT  writeBack,
    output decodedT    decoded,
    output logic       decValid,
    input  regAddrT    RegAddr,
    output dataT       RegData
);

    dataT    rsData;
    dataT    rtData;
    decodedT nextDecoded;
    logic    hazard;
    logic    readsRt;

    registerFile regs (
        .Clock    (Clock),
        .nReset   (nReset),
        .rsAddr   (instr.rs),
        .rtAddr   (instr.rt),
        .rsData   (rsData),
        .rtData   (rtData),
        .writeBack(writeBack),
        .RegAddr  (RegAddr),
        .RegData  (RegData)
    );

    // youngest producer wins
    function automatic dataT pickOperand(regAddrT addr, dataT fileValue);
        dataT value;
        value = fileValue;
        if (addr == '0)
            value = '0;
        else if (decValid && decoded.we && decoded.op != opMul && decoded.rd == addr)
            value = aluFwd;
        else if (midFwdValid && midFwd.we && !midFwd.isMul && midFwd.rd == addr)
            value = midFwd.value;
        else if (execFwdValid && execFwd.we && execFwd.rd == addr)
            value = execFwd.value;
        return value;
    endfunction

    assign readsRt = instr.opCode != opShl && instr.opCode != opAddImm;

    // a multiply has no product until it leaves the second execute stage
    always_comb begin
        hazard = 1'b0;
        if (busyMul && busyMulRd != '0 &&
            (instr.rs == busyMulRd || (readsRt && instr.rt == busyMulRd)))
            hazard = 1'b1;
        if (midFwdValid && midFwd.isMul && midFwd.we && midFwd.rd != '0 &&
            (instr.rs == midFwd.rd || (readsRt && instr.rt == midFwd.rd)))
            hazard = 1'b1;
        hazard = hazard && instrValid;
    end

    assign instrReady = !hazard;

    always_comb begin
        nextDecoded.op        = opCodeT'(instr.opCode);
        nextDecoded.rd        = instr.rd;
        nextDecoded.we        = isWriteOp(instr.opCode) && instr.rd != '0;
        nextDecoded.operandA  = pickOperand(instr.rs, rsData);
        nextDecoded.operandB  = pickOperand(instr.rt, rtData);
        nextDecoded.immediate = {{(dataWidth-immWidth){instr.imm[immWidth-1]}}, instr.imm};
        nextDecoded.shamt     = instr.imm[shamtWidth-1:0];
    end

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset)
            decValid <= 1'b0;
        else
            decValid <= instrValid && instrReady; // bubble on stall.
    end

    always_ff @(posedge Clock) begin
        decoded <= nextDecoded;
    end

endmodule

// File: execute/multiplyUnit.sv
`timescale 1ns/1ps

module multiplyUnit import corePkg::*; (
    input  logic Clock,
    input  logic nReset,
    input  dataT a,
    input  dataT b,
    output dataT product
);

    dataT aReg;
    dataT bReg;
    dataT lowProduct;

    always_ff @(posedge Clock) begin
        aReg <= a;
        bReg <= b;
    end

    assign lowProduct = aReg * bReg; // low half only.

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset)
            product <= '0;
        else
            product <= lowProduct;
    end

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ps

module executeStage import corePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  decodedT    decoded,
    input  logic       decValid,
    output dataT       aluFwd,
    output logic       busyMul,
    output regAddrT    busyMulRd,
    output execResultT midFwd,
    output logic       midFwdValid,
    output execResultT execOut,
    output logic       execValid
);

    dataT       aluResult;
    dataT       product;
    execResultT stageOne;
    execResultT stageTwo;
    logic       validOne;
    logic       validTwo;

    always_comb begin
        case (decoded.op)
            opAdd:    aluResult = decoded.operandA + decoded.operandB;
            opSub:    aluResult = decoded.operandA - decoded.operandB;
            opAnd:    aluResult = decoded.operandA & decoded.operandB;
            opOr:     aluResult = decoded.operandA | decoded.operandB;
            opXor:    aluResult = decoded.operandA ^ decoded.operandB;
            opShl:    aluResult = decoded.operandA << decoded.shamt;
            opAddImm: aluResult = decoded.operandA + decoded.immediate;
            default:  aluResult = '0; // multiply and no-op.
        endcase
    end

    assign aluFwd    = aluResult;
    assign busyMul   = decValid && decoded.we && decoded.op == opMul;
    assign busyMulRd = decoded.rd;

    multiplyUnit mul (
        .Clock  (Clock),
        .nReset (nReset),
        .a      (decoded.operandA),
        .b      (decoded.operandB),
        .product(product)
    );

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            validOne <= 1'b0;
            validTwo <= 1'b0;
        end else begin
            validOne <= decValid;
            validTwo <= validOne;
        end
    end

    always_ff @(posedge Clock) begin
        stageOne.rd    <= decoded.rd;
        stageOne.we    <= decoded.we;
        stageOne.isMul <= decoded.op == opMul;
        stageOne.value <= aluResult;
        stageTwo       <= stageOne;
    end

    assign midFwd      = stageOne;
    assign midFwdValid = validOne;

    // product lands together with the op in stage two
    always_comb begin
        execOut = stageTwo;
        if (stageTwo.isMul)
            execOut.value = product;
    end

    assign execValid = validTwo;

endmodule

// File: src/resultStage.sv
`timescale 1ns/1ps

module resultStage import corePkg::*; (
    input  logic       Clock,
    input  logic       nReset,
    input  execResultT execIn,
    input  logic       execValid,
    output writeBackT  writeBack
);

    writeBackT nextWrite;

    always_comb begin
        nextWrite.en   = execValid && execIn.we && execIn.rd != '0;
        nextWrite.addr = execIn.rd;
        nextWrite.data = execIn.value;
    end

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset)
            writeBack <= '0;
        else
            writeBack <= nextWrite;
    end

endmodule

// File: src/processorCore.sv
`timescale 1ns/1ps

module processorCore import corePkg::*; (
    input  logic    Clock,
    input  logic    nReset,
    input  logic    instrValid,
    output logic    instrReady,
    input  instrT   instr,
    input  regAddrT RegAddr,
    output dataT    RegData
);

    decodedT    decoded;
    logic       decValid;
    dataT       aluFwd;
    logic       busyMul;
    regAddrT    busyMulRd;
    execResultT midFwd;
    logic       midFwdValid;
    execResultT execOut;
    logic       execValid;
    writeBackT  writeBack;

    instrDecode decode (
        .Clock       (Clock),
        .nReset      (nReset),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .midFwd      (midFwd),
        .midFwdValid (midFwdValid),
        .execFwd     (execOut),
        .execFwdValid(execValid),
        .aluFwd      (aluFwd),
        .busyMul     (busyMul),
        .busyMulRd   (busyMulRd),
        .writeBack   (writeBack),
        .decoded     (decoded),
        .decValid    (decValid),
        .RegAddr     (RegAddr),
        .RegData     (RegData)
    );

    executeStage execute (
        .Clock      (Clock),
        .nReset     (nReset),
        .decoded    (decoded),
        .decValid   (decValid),
        .aluFwd     (aluFwd),
        .busyMul    (busyMul),
        .busyMulRd  (busyMulRd),
        .midFwd     (midFwd),
        .midFwdValid(midFwdValid),
        .execOut    (execOut),
        .execValid  (execValid)
    );

    resultStage result (
        .Clock    (Clock),
        .nReset   (nReset),
        .execIn   (execOut),
        .execValid(execValid),
        .writeBack(writeBack)
    );

endmodule

// File: test/processorCore_assertions.sv
`timescale 1ns/1ps

module processorCore_assertions import corePkg::*; (
    input logic       Clock,
    input logic       nReset,
    input logic       instrValid,
    input logic       instrReady,
    input instrT      instr,
    input logic       busyMul,
    input regAddrT    busyMulRd,
    input execResultT midFwd,
    input logic       midFwdValid,
    input writeBackT  writeBack
);

    int   failCount = 0;
    logic readsFirstMul;
    logic readsSecondMul;

    // product exists only once the multiply leaves the second execute stage
    assign readsFirstMul = busyMul && (instr.rs == busyMulRd || instr.rt == busyMulRd);
    assign readsSecondMul = midFwdValid && midFwd.isMul && midFwd.we &&
        (instr.rs == midFwd.rd || instr.rt == midFwd.rd);

    stallOnlyOnMulHazard: assert property (@(posedge Clock) disable iff (!nReset)
        !instrReady |-> instrValid && (readsFirstMul || readsSecondMul))
    else begin
        $error("instrReady low without a pending multiply result");
        failCount++;
    end

    heldWordStable: assert property (@(posedge Clock) disable iff (!nReset)
        instrValid && !instrReady |=> instrValid && $stable(instr))
    else begin
        $error("instruction word changed while stalled");
        failCount++;
    end

    noWriteToZero: assert property (@(posedge Clock) disable iff (!nReset)
        writeBack.en |-> writeBack.addr != '0)
    else begin
        $error("write-back to register 0");
        failCount++;
    end

    quietInReset: assert property (@(posedge Clock)
        !nReset |-> instrReady && !writeBack.en)
    else begin
        $error("ready low or register write during reset");
        failCount++;
    end

endmodule

bind processorCore processorCore_assertions coreChecks (
    .Clock      (Clock),
    .nReset     (nReset),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .busyMul    (busyMul),
    .busyMulRd  (busyMulRd),
    .midFwd     (midFwd),
    .midFwdValid(midFwdValid),
    .writeBack  (writeBack)
);

// File: test/coreTb.sv
`timescale 1ns/1ps

module coreTb import corePkg::*; ();

    localparam int randomWords = 300;
    localparam int maxGap = 3;
    // worst case per random word is a gap, the accept cycle and a two cycle stall
    localparam int stimulusCycles = 16 + 2 * regCount + 40 * 4 + randomWords * (maxGap + 3);
    localparam int timeoutCycles = stimulusCycles + 200;

    logic    Clock;
    logic    nReset;
    logic    instrValid;
    logic    instrReady;
    instrT   instr;
    regAddrT RegAddr;
    dataT    RegData;

    dataT    model [regCount];
    int      dueCycles [$];
    regAddrT dueAddrs [$];
    dataT    dueValues [$];
    int      cycleCount = 0;
    int      checkCount = 0;
    int      errorCount = 0;
    int      testCount = 0;
    int      firstCheck = 0;
    int      firstError = 0;
    int      stallCycles = 0;
    int      assertFailures = 0;

    processorCore UUT (
        .Clock     (Clock),
        .nReset    (nReset),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instr     (instr),
        .RegAddr   (RegAddr),
        .RegData   (RegData)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    initial begin : timeoutWatch
        while (cycleCount < timeoutCycles) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("timeout: run did not complete within %0d cycles", timeoutCycles);
        $display("Finished with errors");
        $finish;
    end

    // one debug read per cycle, sampled mid-cycle.
    initial begin : debugReader
        forever begin
            @(posedge Clock);
            #1;
            if (dueCycles.size() != 0 && dueCycles[0] == cycleCount) begin
                RegAddr = dueAddrs[0];
                @(negedge Clock);
                checkCount++;
                assert (RegData === dueValues[0]) else begin
                    errorCount++;
                    $display("** Error at %0t ns: RegData (r%0d) = %h, expected %h",
                        $time, dueAddrs[0], RegData, dueValues[0]);
                end
                void'(dueCycles.pop_front());
                void'(dueAddrs.pop_front());
                void'(dueValues.pop_front());
            end
        end
    end

    function automatic instrT encode(logic [5:0] code, int rd, int rs, int rt, int imm);
        instrT w;
        w.opCode = code;
        w.rd     = 5'(rd);
        w.rs     = 5'(rs);
        w.rt     = 5'(rt);
        w.imm    = 11'(imm);
        return w;
    endfunction

    task automatic queueCheck(int due, regAddrT addr, dataT value);
        dueCycles.push_back(due);
        dueAddrs.push_back(addr);
        dueValues.push_back(value);
    endtask

    // reference register model, updated in acceptance order
    task automatic applyWord(instrT w);
        dataT a;
        dataT b;
        dataT imm;
        dataT value;
        logic writes;
        a = model[w.rs];
        b = model[w.rt];
        imm = {{(dataWidth-immWidth){w.imm[immWidth-1]}}, w.imm};
        value = '0;
        writes = 1'b1;
        case (w.opCode)
            opAdd:    value = a + b;
            opSub:    value = a - b;
            opAnd:    value = a & b;
            opOr:     value = a | b;
            opXor:    value = a ^ b;
            opShl:    value = a << w.imm[4:0];
            opAddImm: value = a + imm;
            opMul:    value = a * b;
            default:  writes = 1'b0;
        endcase
        if (writes && w.rd != '0)
            model[w.rd] = value;
        queueCheck(cycleCount + 4, w.rd, model[w.rd]); // lands at edge N+4.
    endtask

    task automatic sendWord(instrT w);
        stallCycles = 0;
        instrValid = 1'b1;
        instr = w;
        @(negedge Clock);
        while (!instrReady) begin
            stallCycles++;
            @(negedge Clock);
        end
        applyWord(w);
        @(posedge Clock);
        #1;
    endtask

    task automatic idle(int cycles);
        instrValid = 1'b0;
        repeat (cycles) begin
            @(posedge Clock);
            #1;
        end
    endtask

    task automatic drainChecks();
        instrValid = 1'b0;
        while (dueCycles.size() != 0) begin
            @(posedge Clock);
            #1;
        end
    endtask

    task automatic finishTest(string name);
        drainChecks();
        testCount++;
        $display("test %0d %s: %0d checks, %0d errors", testCount, name,
            checkCount - firstCheck, errorCount - firstError);
        firstCheck = checkCount;
        firstError = errorCount;
    endtask

    task automatic expectStall();
        assert (stallCycles != 0) else begin
            errorCount++;
            $display("no stall at %0t ns for a word reading a pending multiply", $time);
        end
    endtask

    initial begin : stimulus
        int unsigned pick;
        logic [5:0]  code;
        nReset = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        RegAddr = '0;
        void'($urandom(67));
        for (int r = 0; r < regCount; r++)
            model[r] = '0;
        repeat (16) @(posedge Clock);
        #1;
        assert (instrReady) else begin
            errorCount++;
            $display("instrReady is low during reset");
        end
        nReset = 1'b1;

        for (int r = 0; r < regCount; r++)
            queueCheck(cycleCount + 1 + r, 5'(r), '0);
        drainChecks();
        sendWord(encode(opAddImm, 0, 0, 0, 99));
        sendWord(encode(opOr, 0, 0, 0, 0));
        finishTest("reset");

        sendWord(encode(opAddImm, 1, 0, 0, 1000));
        sendWord(encode(opShl, 2, 1, 0, 12));
        sendWord(encode(opAddImm, 3, 0, 0, -77));
        idle(5); // operands now come from the register file.
        sendWord(encode(opAdd, 10, 1, 2, 0));
        sendWord(encode(opSub, 11, 1, 3, 0));
        sendWord(encode(opAnd, 12, 2, 3, 0));
        sendWord(encode(opOr, 13, 1, 3, 0));
        sendWord(encode(opXor, 14, 2, 3, 0));
        sendWord(encode(opShl, 15, 3, 0, 7));
        sendWord(encode(opAddImm, 16, 2, 0, -1000));
        finishTest("independent alu");

        sendWord(encode(opAddImm, 20, 0, 0, 7));
        sendWord(encode(opAdd, 21, 20, 20, 0));
        sendWord(encode(opSub, 22, 21, 20, 0));
        sendWord(encode(opXor, 23, 22, 20, 0));
        sendWord(encode(opOr, 24, 23, 20, 0));
        sendWord(encode(opShl, 25, 24, 0, 3));
        sendWord(encode(opAdd, 26, 25, 20, 0));
        sendWord(encode(opAddImm, 0, 26, 0, 1));
        sendWord(encode(opAdd, 27, 0, 26, 0)); // r0 must not forward.
        finishTest("dependent alu");

        sendWord(encode(opAddImm, 5, 0, 0, 123));
        sendWord(encode(opAddImm, 6, 0, 0, -45));
        idle(4);
        sendWord(encode(opMul, 7, 5, 6, 0));
        sendWord(encode(opAdd, 8, 7, 5, 0));
        expectStall();
        sendWord(encode(opMul, 9, 8, 8, 0));
        sendWord(encode(opAddImm, 10, 9, 0, 1));
        expectStall();
        finishTest("multiply hazard");

        for (int i = 0; i < randomWords; i++) begin
            pick = $urandom % 10;
            if (pick < 8)
                code = 6'(pick + 1);
            else if (pick == 8)
                code = 6'h00;
            else
                code = 6'h3f;
            sendWord(encode(code, $urandom % 8, $urandom % 8, $urandom % 8, $urandom));
            if ($urandom % 4 == 0)
                idle(int'($urandom % maxGap) + 1);
        end
        finishTest("random stream");

        assertFailures = UUT.coreChecks.failCount;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
            testCount, checkCount, errorCount, assertFailures);
        if (errorCount == 0 && assertFailures == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: project.f
common/corePkg.sv
decode/registerFile.sv
decode/instrDecode.sv
execute/multiplyUnit.sv
execute/executeStage.sv
src/resultStage.sv
src/processorCore.sv
test/processorCore_assertions.sv
test/coreTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreTb -f project.f -o coreSim || exit 1

# assertion errors are counted by the testbench instead of stopping the run
simOutput=$(./obj_dir/coreSim +verilator+error+limit+100000)
echo "$simOutput"
echo "$simOutput" | grep -qx "Finished with no errors" && exit 0 || exit 1
